// File: sim.f
src/bus_pkg.sv
src/map_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/tim.sv
src/ram.sv
src/clint.sv
src/mem_system.sv
tb/tb_clock.sv
tb/mem_system_sva.sv
tb/mem_system_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_system_tb \
  -f sim.f -Mdir obj_dir -o mem_system_sim

./obj_dir/mem_system_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"

// File: tb/mem_system_tb.sv
`timescale 1ns/1ns

module mem_system_tb;

  localparam int ram_wait = 3;
  localparam int rtc_divider = 4;
  localparam int words = 1024;
  localparam int num_transactions = 1000;
  localparam int worst_cycles = 2 * (ram_wait + 2) + 4;  // a ram access queued behind another.
  localparam int timeout_ns = num_transactions * worst_cycles * 2 * 20 + 20000;

  logic           clock;
  logic           reset;
  logic           imem_valid;
  bus_pkg::addr_t imem_addr;
  bus_pkg::data_t imem_wdata;
  bus_pkg::strb_t imem_wstrb;
  logic           dmem_valid;
  bus_pkg::addr_t dmem_addr;
  bus_pkg::data_t dmem_wdata;
  bus_pkg::strb_t dmem_wstrb;
  logic           imem_ready;
  bus_pkg::data_t imem_rdata;
  logic           imem_error;
  logic           dmem_ready;
  bus_pkg::data_t dmem_rdata;
  logic           dmem_error;
  logic           msip;
  logic           mtip;

  bus_pkg::data_t  tim_model [words];
  bus_pkg::data_t  ram_model [words];
  bit              tim_known [words];
  bit              ram_known [words];
  logic            msip_model;
  bus_pkg::dword_t mtimecmp_model;
  logic            last_mtip;
  int              error_count;

  tb_clock tb_clock_i (
    .clock (clock),
    .reset (reset)
  );

  mem_system #(
    .ram_wait    (ram_wait),
    .rtc_divider (rtc_divider)
  ) mem_system_i (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_wstrb (imem_wstrb),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_error (imem_error),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .dmem_error (dmem_error),
    .msip       (msip),
    .mtip       (mtip)
  );

  bind bus_arbiter mem_system_sva mem_system_sva_i (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_ready (imem_ready),
    .dmem_valid (dmem_valid),
    .dmem_ready (dmem_ready),
    .bus_ready  (bus_ready),
    .state      (state)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  function automatic bus_pkg::data_t merge_bytes(bus_pkg::data_t old_word,
                                                 bus_pkg::data_t new_word,
                                                 bus_pkg::strb_t strb);
    bus_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic bit mapped_address(bus_pkg::addr_t addr);
    return (addr >= map_pkg::tim_base && addr < map_pkg::tim_top)
        || (addr >= map_pkg::clint_base && addr < map_pkg::clint_top)
        || (addr >= map_pkg::ram_base && addr < map_pkg::ram_top);
  endfunction

  task automatic drive_request(input bit use_dmem, input logic valid, input bus_pkg::addr_t addr,
                               input bus_pkg::data_t wdata, input bus_pkg::strb_t wstrb);
    if (use_dmem) begin
      dmem_valid = valid;
      dmem_addr = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
    end else begin
      imem_valid = valid;
      imem_addr = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
    end
  endtask

  // cycles counts the falling edges from the request to ready.
  task automatic bus_access(input bit use_dmem, input bus_pkg::addr_t addr,
                            input bus_pkg::data_t wdata, input bus_pkg::strb_t wstrb,
                            output bus_pkg::data_t rdata, output logic err, output int cycles);
    bit seen;
    seen = 1'b0;
    cycles = 0;
    @(negedge clock);
    drive_request(use_dmem, 1'b1, addr, wdata, wstrb);
    while (!seen) begin
      @(negedge clock);
      cycles++;
      if (use_dmem ? dmem_ready : imem_ready) begin
        seen = 1'b1;
        rdata = use_dmem ? dmem_rdata : imem_rdata;
        err = use_dmem ? dmem_error : imem_error;
        last_mtip = mtip;
      end
    end
    @(negedge clock);
    drive_request(use_dmem, 1'b0, '0, '0, '0);  // the request is held through the ready cycle.
  endtask

  function automatic bus_pkg::data_t load_model(bit in_ram, int idx);
    return in_ram ? ram_model[idx] : tim_model[idx];
  endfunction

  function automatic bit word_known(bit in_ram, int idx);
    return in_ram ? ram_known[idx] : tim_known[idx];
  endfunction

  task automatic store_model(input bit in_ram, input int idx, input bus_pkg::data_t value);
    if (in_ram) begin
      ram_model[idx] = value;
      ram_known[idx] = 1'b1;
    end else begin
      tim_model[idx] = value;
      tim_known[idx] = 1'b1;
    end
  endtask

  // a random write followed by a read of a word that holds known data.
  task automatic memory_round(input bit use_dmem, input bit in_ram, input int lo, input int span,
                              input bit timed, input string name);
    int             idx;
    int             other;
    int             expected_cycles;
    int             cycles;
    bus_pkg::addr_t base;
    bus_pkg::strb_t strb;
    bus_pkg::data_t wdata;
    bus_pkg::data_t rdata;
    logic           err;
    base = in_ram ? map_pkg::ram_base : map_pkg::tim_base;
    expected_cycles = in_ram ? ram_wait + 2 : 2;
    idx = lo + int'($urandom_range(0, span - 1));
    strb = word_known(in_ram, idx) ? bus_pkg::strb_t'($urandom_range(1, 15)) : 4'hf;
    wdata = $urandom;
    bus_access(use_dmem, base + bus_pkg::addr_t'(idx * 4), wdata, strb, rdata, err, cycles);
    store_model(in_ram, idx, merge_bytes(load_model(in_ram, idx), wdata, strb));
    check_value({name, " write error"}, 32'd0, 32'(err));
    if (timed) begin
      check_value({name, " write latency"}, expected_cycles, cycles);
    end
    other = lo + int'($urandom_range(0, span - 1));
    if (!word_known(in_ram, other)) begin
      other = idx;
    end
    bus_access(use_dmem, base + bus_pkg::addr_t'(other * 4), '0, '0, rdata, err, cycles);
    check_value({name, " read data"}, load_model(in_ram, other), rdata);
    check_value({name, " read error"}, 32'd0, 32'(err));
    if (timed) begin
      check_value({name, " read latency"}, expected_cycles, cycles);
    end
  endtask

  task automatic tim_byte_access();
    fork
      begin
        for (int n = 0; n < 100; n++) begin
          repeat ($urandom_range(0, 2)) @(negedge clock);
          memory_round(1'b0, 1'b0, 0, words / 2, 1'b0, "tim imem");
        end
      end
      begin
        for (int n = 0; n < 100; n++) begin
          repeat ($urandom_range(0, 2)) @(negedge clock);
          memory_round(1'b1, 1'b0, words / 2, words / 2, 1'b0, "tim dmem");
        end
      end
    join
  endtask

  task automatic ram_wait_states();
    for (int n = 0; n < 200; n++) begin
      memory_round(bit'($urandom_range(0, 1)), 1'b1, 0, words, 1'b1, "ram");
    end
  endtask

  task automatic unmapped_responses();
    bus_pkg::addr_t addr;
    bus_pkg::data_t rdata;
    logic           err;
    int             cycles;
    for (int n = 0; n < 20; n++) begin
      case (n)
        0: addr = map_pkg::tim_top;
        1: addr = map_pkg::clint_top;
        2: addr = map_pkg::ram_top;
        3: addr = map_pkg::ram_base - 32'd4;
        default: begin
          addr = $urandom & 32'hffff_fffc;
          while (mapped_address(addr)) begin
            addr = $urandom & 32'hffff_fffc;
          end
        end
      endcase
      bus_access(bit'($urandom_range(0, 1)), addr, $urandom, bus_pkg::strb_t'($urandom), rdata,
                 err, cycles);
      check_value("unmapped error", 32'd1, 32'(err));
      check_value("unmapped rdata", 32'd0, rdata);
      check_value("unmapped latency", 32'd2, cycles);
      memory_round(bit'($urandom_range(0, 1)), 1'b0, 0, words, 1'b1, "tim after unmapped");
    end
  endtask

  task automatic arbitration_order();
    int             a;
    int             b;
    bus_pkg::data_t rdata_i;
    bus_pkg::data_t rdata_d;
    logic           err_i;
    logic           err_d;
    int             cycles_i;
    int             cycles_d;
    for (int n = 0; n < 10; n++) begin
      a = $urandom_range(0, words - 1);
      while (!tim_known[a]) begin
        a = $urandom_range(0, words - 1);
      end
      b = a;
      while (b == a || !tim_known[b]) begin
        b = $urandom_range(0, words - 1);
      end
      fork
        bus_access(1'b0, bus_pkg::addr_t'(a * 4), '0, '0, rdata_i, err_i, cycles_i);
        bus_access(1'b1, bus_pkg::addr_t'(b * 4), '0, '0, rdata_d, err_d, cycles_d);
      join
      check_value("arbitration imem data", tim_model[a], rdata_i);
      check_value("arbitration dmem data", tim_model[b], rdata_d);
      check_value("arbitration errors", 32'd0, 32'(err_i | err_d));
      check_value("arbitration dmem latency", 32'd2, cycles_d);
      check_value("arbitration dmem first", 32'd1, 32'(cycles_d < cycles_i));
    end
  endtask

  task automatic msip_follow();
    bus_pkg::data_t rdata;
    logic           err;
    int             cycles;
    for (int n = 0; n < 2; n++) begin
      msip_model = (n == 0);
      bus_access(1'b1, map_pkg::clint_base + map_pkg::msip_offset, 32'(msip_model), 4'h1, rdata,
                 err, cycles);
      check_value("msip pin", 32'(msip_model), 32'(msip));
      bus_access(1'b1, map_pkg::clint_base + map_pkg::msip_offset, '0, '0, rdata, err, cycles);
      check_value("msip readback", 32'(msip_model), rdata);
      check_value("msip error", 32'd0, 32'(err));
    end
  endtask

  task automatic timer_interrupt();
    bus_pkg::addr_t mtime_addr;
    bus_pkg::addr_t cmp_addr;
    bus_pkg::data_t first;
    bus_pkg::data_t second;
    bus_pkg::data_t now;
    bus_pkg::data_t rdata;
    logic           err;
    int             cycles;
    bit             reached;
    mtime_addr = map_pkg::clint_base + map_pkg::mtime_offset;
    cmp_addr = map_pkg::clint_base + map_pkg::mtimecmp_offset;
    bus_access(1'b1, cmp_addr, '0, '0, rdata, err, cycles);
    check_value("mtimecmp reset value", mtimecmp_model[31:0], rdata);
    bus_access(1'b1, mtime_addr, '0, '0, first, err, cycles);
    repeat (40) @(negedge clock);
    bus_access(1'b1, mtime_addr, '0, '0, second, err, cycles);
    check_value("mtime advances", 32'd1, 32'(second > first));  // many prescaler periods apart.
    // the low word goes first so the compare value never passes through a small number.
    mtimecmp_model = {32'h0, second + 32'd5};
    bus_access(1'b1, cmp_addr, mtimecmp_model[31:0], 4'hf, rdata, err, cycles);
    bus_access(1'b1, cmp_addr + 32'd4, mtimecmp_model[63:32], 4'hf, rdata, err, cycles);
    bus_access(1'b1, cmp_addr, '0, '0, rdata, err, cycles);
    check_value("mtimecmp readback", mtimecmp_model[31:0], rdata);
    reached = 1'b0;
    for (int n = 0; n < 60 && !reached; n++) begin
      bus_access(1'b1, mtime_addr, '0, '0, now, err, cycles);
      check_value("mtip against mtime", 32'(now >= mtimecmp_model[31:0]), 32'(last_mtip));
      reached = (now >= mtimecmp_model[31:0]);
    end
    if (!reached) begin
      $display("Timer test: mtime never reached mtimecmp within the poll limit");
      error_count++;
    end
    repeat (10) @(negedge clock);
    check_value("mtip stays high", 32'd1, 32'(mtip));
  endtask

  initial begin
    int assertion_failures;
    void'($urandom(32'hf848));
    error_count = 0;
    last_mtip = 1'b0;
    msip_model = 1'b0;
    mtimecmp_model = '1;
    drive_request(1'b0, 1'b0, '0, '0, '0);
    drive_request(1'b1, 1'b0, '0, '0, '0);
    wait (reset === 1'b1);
    @(negedge clock);
    check_value("msip after reset", 32'd0, 32'(msip));
    check_value("mtip after reset", 32'd0, 32'(mtip));
    tim_byte_access();
    ram_wait_states();
    unmapped_responses();
    arbitration_order();
    msip_follow();
    timer_interrupt();
    repeat (4) @(negedge clock);
    assertion_failures = mem_system_i.bus_arbiter_i.mem_system_sva_i.fail_count;
    $display("Check errors: %0d, assertion failures: %0d", error_count, assertion_failures);
    if (error_count == 0 && assertion_failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Watchdog: the run did not finish within %0d ns", timeout_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: tb/mem_system_sva.sv
`timescale 1ns/1ns

module mem_system_sva (
  input logic       clock,
  input logic       reset,
  input logic       imem_valid,
  input logic       imem_ready,
  input logic       dmem_valid,
  input logic       dmem_ready,
  input logic       bus_ready,
  input logic [1:0] state
);

  int fail_count = 0;

  imem_held: assert property (@(posedge clock) disable iff (!reset)
    imem_valid && !imem_ready |=> imem_valid)
    else begin
      $error("instruction master dropped valid before ready");
      fail_count++;
    end

  dmem_held: assert property (@(posedge clock) disable iff (!reset)
    dmem_valid && !dmem_ready |=> dmem_valid)
    else begin
      $error("data master dropped valid before ready");
      fail_count++;
    end

  one_ready: assert property (@(posedge clock) disable iff (!reset)
    !(imem_ready && dmem_ready))
    else begin
      $error("ready raised at both masters in the same cycle");
      fail_count++;
    end

  // idle is the first state of the arbiter, encoded as zero.
  grant_stable: assert property (@(posedge clock) disable iff (!reset)
    state != 2'd0 && !bus_ready |=> $stable(state))
    else begin
      $error("grant changed while a transaction was open");
      fail_count++;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int period = 20,
  parameter int reset_cycles = 2
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever begin
      #(period / 2);
      clock = ~clock;
    end
  end

  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;  // released on a falling edge, away from the sampling edge.
  end

endmodule

// File: src/mem_system.sv
`timescale 1ns/1ns

module mem_system #(
  parameter int tim_words = 1024,
  parameter int ram_words = 1024,
  parameter int ram_wait = 3,
  parameter int rtc_divider = 4
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           imem_valid,
  input  bus_pkg::addr_t imem_addr,
  input  bus_pkg::data_t imem_wdata,
  input  bus_pkg::strb_t imem_wstrb,
  input  logic           dmem_valid,
  input  bus_pkg::addr_t dmem_addr,
  input  bus_pkg::data_t dmem_wdata,
  input  bus_pkg::strb_t dmem_wstrb,
  output logic           imem_ready,
  output bus_pkg::data_t imem_rdata,
  output logic           imem_error,
  output logic           dmem_ready,
  output bus_pkg::data_t dmem_rdata,
  output logic           dmem_error,
  output logic           msip,
  output logic           mtip
);

  logic           bus_valid;
  bus_pkg::addr_t bus_addr;
  bus_pkg::data_t bus_wdata;
  bus_pkg::strb_t bus_wstrb;
  logic           bus_ready;
  bus_pkg::data_t bus_rdata;
  logic           bus_error;

  logic           tim_valid;
  logic           ram_valid;
  logic           clint_valid;
  bus_pkg::addr_t tgt_addr;
  bus_pkg::data_t tgt_wdata;
  bus_pkg::strb_t tgt_wstrb;

  logic           tim_ready;
  bus_pkg::data_t tim_rdata;
  logic           ram_ready;
  bus_pkg::data_t ram_rdata;
  logic           clint_ready;
  bus_pkg::data_t clint_rdata;

  bus_arbiter bus_arbiter_i (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_wstrb (imem_wstrb),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .bus_ready  (bus_ready),
    .bus_rdata  (bus_rdata),
    .bus_error  (bus_error),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_error (imem_error),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata),
    .dmem_error (dmem_error),
    .bus_valid  (bus_valid),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_wstrb  (bus_wstrb)
  );

  bus_decoder bus_decoder_i (
    .clock       (clock),
    .reset       (reset),
    .bus_valid   (bus_valid),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_wstrb   (bus_wstrb),
    .tim_ready   (tim_ready),
    .tim_rdata   (tim_rdata),
    .ram_ready   (ram_ready),
    .ram_rdata   (ram_rdata),
    .clint_ready (clint_ready),
    .clint_rdata (clint_rdata),
    .bus_ready   (bus_ready),
    .bus_rdata   (bus_rdata),
    .bus_error   (bus_error),
    .tim_valid   (tim_valid),
    .ram_valid   (ram_valid),
    .clint_valid (clint_valid),
    .tgt_addr    (tgt_addr),
    .tgt_wdata   (tgt_wdata),
    .tgt_wstrb   (tgt_wstrb)
  );

  tim #(
    .tim_words (tim_words)
  ) tim_i (
    .clock (clock),
    .reset (reset),
    .valid (tim_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (tim_ready),
    .rdata (tim_rdata)
  );

  ram #(
    .ram_words (ram_words),
    .ram_wait  (ram_wait)
  ) ram_i (
    .clock (clock),
    .reset (reset),
    .valid (ram_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (ram_ready),
    .rdata (ram_rdata)
  );

  clint #(
    .rtc_divider (rtc_divider)
  ) clint_i (
    .clock (clock),
    .reset (reset),
    .valid (clint_valid),
    .addr  (tgt_addr),
    .wdata (tgt_wdata),
    .wstrb (tgt_wstrb),
    .ready (clint_ready),
    .rdata (clint_rdata),
    .msip  (msip),
    .mtip  (mtip)
  );

endmodule

// File: src/clint.sv
`timescale 1ns/1ns

module clint #(
  parameter int rtc_divider = 4
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           valid,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::data_t wdata,
  input  bus_pkg::strb_t wstrb,
  output logic           ready,
  output bus_pkg::data_t rdata,
  output logic           msip,
  output logic           mtip
);

  localparam int pw = (rtc_divider > 1) ? $clog2(rtc_divider) : 1;

  logic [pw-1:0]   prescale;
  logic            tick;
  logic            accept;
  bus_pkg::dword_t mtime;
  bus_pkg::dword_t mtimecmp;
  bus_pkg::data_t  read_data;

  assign tick = (prescale == pw'(rtc_divider - 1));
  assign accept = valid && !ready;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
      prescale <= '0;
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip <= 1'b0;
    end else begin
      ready <= accept;
      prescale <= tick ? '0 : prescale + 1'b1;
      if (tick) begin
        mtime <= mtime + 1'b1;
      end
      mtip <= (mtime >= mtimecmp);  // one cycle behind the compare.
      if (accept) begin
        if (addr == map_pkg::msip_offset && wstrb[0]) begin
          msip <= wdata[0];
        end
        for (int b = 0; b < bus_pkg::strb_width; b++) begin
          if (wstrb[b] && addr == map_pkg::mtimecmp_offset) begin
            mtimecmp[8*b +: 8] <= wdata[8*b +: 8];
          end
          if (wstrb[b] && addr == map_pkg::mtimecmp_offset + 32'd4) begin
            mtimecmp[32+8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    case (addr)
      map_pkg::msip_offset:             read_data = {31'b0, msip};
      map_pkg::mtimecmp_offset:         read_data = mtimecmp[31:0];
      map_pkg::mtimecmp_offset + 32'd4: read_data = mtimecmp[63:32];
      map_pkg::mtime_offset:            read_data = mtime[31:0];
      map_pkg::mtime_offset + 32'd4:    read_data = mtime[63:32];
      default:                          read_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= read_data;
    end
  end

endmodule

// File: src/ram.sv
`timescale 1ns/1ns

module ram #(
  parameter int ram_words = 1024,
  parameter int ram_wait = 3
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           valid,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::data_t wdata,
  input  bus_pkg::strb_t wstrb,
  output logic           ready,
  output bus_pkg::data_t rdata
);

  localparam int aw = $clog2(ram_words);
  localparam int cw = (ram_wait > 0) ? $clog2(ram_wait + 1) : 1;

  bus_pkg::data_t mem [ram_words];
  logic [aw-1:0]  index;
  logic [cw-1:0]  count;
  logic           busy;
  logic           accept;
  logic           go;

  assign index = addr[aw+1:2];
  assign accept = valid && !busy && !ready;
  // the access happens on the last wait cycle, while the master still holds the request.
  assign go = (busy && count == cw'(1)) || (accept && ram_wait == 0);

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= go;
      if (accept && ram_wait != 0) begin
        busy <= 1'b1;
        count <= cw'(ram_wait);
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == cw'(1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (go) begin
      rdata <= mem[index];
      for (int b = 0; b < bus_pkg::strb_width; b++) begin
        if (wstrb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: src/tim.sv
`timescale 1ns/1ns

module tim #(
  parameter int tim_words = 1024
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           valid,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::data_t wdata,
  input  bus_pkg::strb_t wstrb,
  output logic           ready,
  output bus_pkg::data_t rdata
);

  localparam int aw = $clog2(tim_words);

  bus_pkg::data_t mem [tim_words];
  logic [aw-1:0]  index;
  logic           accept;

  assign index = addr[aw+1:2];  // upper address bits wrap.
  assign accept = valid && !ready;

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata <= mem[index];  // old contents even on a write.
      for (int b = 0; b < bus_pkg::strb_width; b++) begin
        if (wstrb[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: src/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder (
  input  logic           clock,
  input  logic           reset,
  input  logic           bus_valid,
  input  bus_pkg::addr_t bus_addr,
  input  bus_pkg::data_t bus_wdata,
  input  bus_pkg::strb_t bus_wstrb,
  input  logic           tim_ready,
  input  bus_pkg::data_t tim_rdata,
  input  logic           ram_ready,
  input  bus_pkg::data_t ram_rdata,
  input  logic           clint_ready,
  input  bus_pkg::data_t clint_rdata,
  output logic           bus_ready,
  output bus_pkg::data_t bus_rdata,
  output logic           bus_error,
  output logic           tim_valid,
  output logic           ram_valid,
  output logic           clint_valid,
  output bus_pkg::addr_t tgt_addr,
  output bus_pkg::data_t tgt_wdata,
  output bus_pkg::strb_t tgt_wstrb
);

  logic           err_valid;
  logic           err_ready;
  bus_pkg::addr_t base;

  function automatic logic in_range(bus_pkg::addr_t addr, bus_pkg::addr_t lo,
                                    bus_pkg::addr_t hi);
    return (addr >= lo) && (addr < hi);
  endfunction

  always_comb begin
    tim_valid = 1'b0;
    ram_valid = 1'b0;
    clint_valid = 1'b0;
    err_valid = 1'b0;
    base = '0;
    if (bus_valid) begin
      if (in_range(bus_addr, map_pkg::tim_base, map_pkg::tim_top)) begin
        tim_valid = 1'b1;
        base = map_pkg::tim_base;
      end else if (in_range(bus_addr, map_pkg::clint_base, map_pkg::clint_top)) begin
        clint_valid = 1'b1;
        base = map_pkg::clint_base;
      end else if (in_range(bus_addr, map_pkg::ram_base, map_pkg::ram_top)) begin
        ram_valid = 1'b1;
        base = map_pkg::ram_base;
      end else begin
        err_valid = 1'b1;  // nobody claims this address.
      end
    end
    tgt_addr = bus_addr - base;
    tgt_wdata = bus_wdata;
    tgt_wstrb = bus_wstrb;
  end

  // error responder, answers one cycle after an unmapped request.
  always_ff @(posedge clock) begin
    if (!reset) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= err_valid && !err_ready;
    end
  end

  always_comb begin
    bus_ready = tim_ready || ram_ready || clint_ready || err_ready;
    bus_rdata = ({32{tim_ready}} & tim_rdata)
              | ({32{ram_ready}} & ram_rdata)
              | ({32{clint_ready}} & clint_rdata);  // the error response reads as zero.
    bus_error = err_ready;
  end

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
  input  logic           clock,
  input  logic           reset,
  input  logic           imem_valid,
  input  bus_pkg::addr_t imem_addr,
  input  bus_pkg::data_t imem_wdata,
  input  bus_pkg::strb_t imem_wstrb,
  input  logic           dmem_valid,
  input  bus_pkg::addr_t dmem_addr,
  input  bus_pkg::data_t dmem_wdata,
  input  bus_pkg::strb_t dmem_wstrb,
  input  logic           bus_ready,
  input  bus_pkg::data_t bus_rdata,
  input  logic           bus_error,
  output logic           imem_ready,
  output bus_pkg::data_t imem_rdata,
  output logic           imem_error,
  output logic           dmem_ready,
  output bus_pkg::data_t dmem_rdata,
  output logic           dmem_error,
  output logic           bus_valid,
  output bus_pkg::addr_t bus_addr,
  output bus_pkg::data_t bus_wdata,
  output bus_pkg::strb_t bus_wstrb
);

  typedef enum logic [1:0] {
    idle,
    grant_i,
    grant_d
  } state_t;

  state_t state;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (dmem_valid) begin
            state <= grant_d;  // data port wins a tie.
          end else if (imem_valid) begin
            state <= grant_i;
          end
        end
        grant_i, grant_d: begin
          if (bus_ready) begin
            state <= idle;  // one idle cycle before the next grant.
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_comb begin
    if (state == grant_d) begin
      bus_addr = dmem_addr;
      bus_wdata = dmem_wdata;
      bus_wstrb = dmem_wstrb;
    end else begin
      bus_addr = imem_addr;
      bus_wdata = imem_wdata;
      bus_wstrb = imem_wstrb;
    end
    bus_valid = (state == grant_i && imem_valid) || (state == grant_d && dmem_valid);

    imem_ready = (state == grant_i) && bus_ready;
    imem_rdata = (state == grant_i) ? bus_rdata : '0;
    imem_error = (state == grant_i) && bus_error;
    dmem_ready = (state == grant_d) && bus_ready;
    dmem_rdata = (state == grant_d) ? bus_rdata : '0;
    dmem_error = (state == grant_d) && bus_error;
  end

endmodule

// File: src/map_pkg.sv
package map_pkg;

  localparam bus_pkg::addr_t tim_base = 32'h0000_0000;
  localparam bus_pkg::addr_t tim_top = 32'h0000_1000;
  localparam bus_pkg::addr_t clint_base = 32'h0200_0000;
  localparam bus_pkg::addr_t clint_top = 32'h0200_C000;
  localparam bus_pkg::addr_t ram_base = 32'h1000_0000;
  localparam bus_pkg::addr_t ram_top = 32'h1000_1000;

  // offsets inside the clint window, after the base is removed.
  localparam bus_pkg::addr_t msip_offset = 32'h0000_0000;
  localparam bus_pkg::addr_t mtimecmp_offset = 32'h0000_4000;  // upper word at +4.
  localparam bus_pkg::addr_t mtime_offset = 32'h0000_BFF8;  // upper word at +4.

endpackage

// File: src/bus_pkg.sv
package bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;  // one strobe per byte lane.
  localparam int timer_width = 64;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;  // all zeros marks a read.
  typedef logic [timer_width-1:0] dword_t;

endpackage
